//--- Bender.yml
package:
  name: mem_bench

export_include_dirs:
  - logic

sources:
  - files:
      - logic/bench_pkg.sv
      - logic/access_engine.sv
      - logic/cmd_arbiter.sv
      - logic/bench_ctrl.sv
      - logic/bench_top.sv
  - target: test
    files:
      - dv/bench_assertions.sv
      - dv/bench_tb.sv

//--- dv/bench_assertions.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module bench_assertions (
   input  logic                         user_clk,
   input  logic                         user_aresetn,
   input  logic                         mem_cmd_valid,
   input  logic                         mem_cmd_ready,
   input  logic [`BENCH_ID_W-1:0]       mem_cmd_id,
   input  bench_pkg::mem_op_e           mem_cmd_op,
   input  logic [`BENCH_ADDR_W-1:0]     mem_cmd_addr,
   input  logic [`BENCH_LEN_W-1:0]      mem_cmd_len,
   input  logic                         result_valid,
   input  logic [`BENCH_ID_W-1:0]       result_engine
);

   int fail_cnt = 0;  // failed checks so far

   // stalled command holds all fields
   a_cmd_stable: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd_id)
         && $stable(mem_cmd_op) && $stable(mem_cmd_addr) && $stable(mem_cmd_len))
   else begin
      fail_cnt++;
      $error("memory command changed while stalled");
   end

   // a tie gives two back-to-back results, but never one engine twice
   a_result_pulse: assert property (@(posedge user_clk) disable iff (!user_aresetn)
      result_valid |=> !(result_valid && result_engine == $past(result_engine)))
   else begin
      fail_cnt++;
      $error("result_valid held for more than one cycle");
   end

   // engine state is unknown until the first reset edge
   a_reset_quiet: assert property (@(posedge user_clk)
      !user_aresetn ##1 !user_aresetn |-> !mem_cmd_valid)
   else begin
      fail_cnt++;
      $error("mem_cmd_valid high during reset");
   end

endmodule

//--- dv/bench_tb.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module bench_tb;

   import bench_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;

   logic                         user_clk;
   logic                         user_aresetn;
   logic                         bench_cmd_valid;
   logic                         bench_cmd_ready;
   logic [`BENCH_ID_W-1:0]       bench_cmd_dest;
   logic [`BENCH_ADDR_W-1:0]     bench_cmd_base;
   logic [`BENCH_ADDR_W-1:0]     bench_cmd_mem_size;
   logic [`BENCH_LEN_W-1:0]      bench_cmd_num_accesses;
   logic [`BENCH_LEN_W-1:0]      bench_cmd_chunk_len;
   logic [`BENCH_LEN_W-1:0]      bench_cmd_stride;
   logic                         bench_cmd_is_write;
   logic                         mem_cmd_valid;
   logic                         mem_cmd_ready;
   logic [`BENCH_ID_W-1:0]       mem_cmd_id;
   mem_op_e                      mem_cmd_op;
   logic [`BENCH_ADDR_W-1:0]     mem_cmd_addr;
   logic [`BENCH_LEN_W-1:0]      mem_cmd_len;
   logic                         mem_done;
   logic [`BENCH_ID_W-1:0]       mem_done_id;
   logic                         result_valid;
   logic [`BENCH_ID_W-1:0]       result_engine;
   logic [`BENCH_CYCLES_W-1:0]   result_cycles;

   bit                ready_random;      // memory back-pressure on or off
   int unsigned       cyc = 0;           // edge counter
   int unsigned       due_q[$];          // completions waiting to be returned
   bit                pend_id_q[$];
   bit                xfer_id[$];        // log of transferred commands
   mem_op_e           xfer_op[$];
   longint unsigned   xfer_addr[$];
   longint unsigned   xfer_len[$];
   int unsigned       hs_cyc [2];
   int unsigned       last_done_cyc [2];
   int                hs_cnt = 0;
   bit                res_engine[$];
   longint unsigned   res_cycles[$];
   longint unsigned   res_exp[$];
   int unsigned       res_lag[$];

   bench_top u_dut (
      .user_clk               (user_clk),
      .user_aresetn           (user_aresetn),
      .bench_cmd_valid        (bench_cmd_valid),
      .bench_cmd_ready        (bench_cmd_ready),
      .bench_cmd_dest         (bench_cmd_dest),
      .bench_cmd_base         (bench_cmd_base),
      .bench_cmd_mem_size     (bench_cmd_mem_size),
      .bench_cmd_num_accesses (bench_cmd_num_accesses),
      .bench_cmd_chunk_len    (bench_cmd_chunk_len),
      .bench_cmd_stride       (bench_cmd_stride),
      .bench_cmd_is_write     (bench_cmd_is_write),
      .mem_cmd_valid          (mem_cmd_valid),
      .mem_cmd_ready          (mem_cmd_ready),
      .mem_cmd_id             (mem_cmd_id),
      .mem_cmd_op             (mem_cmd_op),
      .mem_cmd_addr           (mem_cmd_addr),
      .mem_cmd_len            (mem_cmd_len),
      .mem_done               (mem_done),
      .mem_done_id            (mem_done_id),
      .result_valid           (result_valid),
      .result_engine          (result_engine),
      .result_cycles          (result_cycles)
   );

   bind bench_top bench_assertions u_assert (
      .user_clk      (user_clk),
      .user_aresetn  (user_aresetn),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd_id    (mem_cmd_id),
      .mem_cmd_op    (mem_cmd_op),
      .mem_cmd_addr  (mem_cmd_addr),
      .mem_cmd_len   (mem_cmd_len),
      .result_valid  (result_valid),
      .result_engine (result_engine)
   );

   always #10 user_clk = ~user_clk;

   // memory model and monitor on pre-edge values
   initial begin : mem_model
      int idx;
      void'($urandom(51712));
      forever begin
         @(posedge user_clk);
         idx = -1;
         cyc <= cyc + 1;
         mem_cmd_ready <= ready_random ? (($urandom % 2) == 1) : 1'b1;
         if (user_aresetn === 1'b1) begin
            if (bench_cmd_valid === 1'b1 && bench_cmd_ready === 1'b1) begin
               hs_cyc[bench_cmd_dest] = cyc;
               hs_cnt++;
            end
            if (mem_cmd_valid === 1'b1 && mem_cmd_ready === 1'b1) begin
               xfer_id.push_back(mem_cmd_id);
               xfer_op.push_back(mem_cmd_op);
               xfer_addr.push_back(mem_cmd_addr);
               xfer_len.push_back(mem_cmd_len);
               due_q.push_back(cyc + ($urandom % 8));  // 1 to 8 cycles later
               pend_id_q.push_back(mem_cmd_id);
            end
            if (mem_done === 1'b1) begin
               last_done_cyc[mem_done_id] = cyc;
            end
            if (result_valid === 1'b1) begin
               res_engine.push_back(result_engine);
               res_cycles.push_back(result_cycles);
               // start pulse one cycle after the handshake and both ends count
               res_exp.push_back(last_done_cyc[result_engine]
                                 - (hs_cyc[result_engine] + 1) + 1);
               res_lag.push_back(cyc - last_done_cyc[result_engine]);
            end
         end
         foreach (due_q[i]) begin
            if (idx < 0 && due_q[i] <= cyc) begin
               idx = i;
            end
         end
         if (idx >= 0) begin
            mem_done    <= 1'b1;
            mem_done_id <= pend_id_q[idx];
            due_q.delete(idx);
            pend_id_q.delete(idx);
         end else begin
            mem_done <= 1'b0;
         end
      end
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input longint unsigned got,
                              input longint unsigned exp);
      assert (got == exp) else
         stop_on_error($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
                                 $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else
         stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
                                 $time, name, got, exp));
   endtask

   task automatic clear_log();
      xfer_id.delete();
      xfer_op.delete();
      xfer_addr.delete();
      xfer_len.delete();
   endtask

   task automatic send_cmd(input bit dest, input logic [`BENCH_ADDR_W-1:0] base,
                           input logic [`BENCH_ADDR_W-1:0] size,
                           input logic [`BENCH_LEN_W-1:0] num,
                           input logic [`BENCH_LEN_W-1:0] chunk,
                           input logic [`BENCH_LEN_W-1:0] stride, input bit is_write);
      int t;
      t = 0;
      @(posedge user_clk);
      bench_cmd_valid        <= 1'b1;
      bench_cmd_dest         <= dest;
      bench_cmd_base         <= base;
      bench_cmd_mem_size     <= size;
      bench_cmd_num_accesses <= num;
      bench_cmd_chunk_len    <= chunk;
      bench_cmd_stride       <= stride;
      bench_cmd_is_write     <= is_write;
      @(posedge user_clk);
      while (bench_cmd_ready !== 1'b1) begin
         t++;
         assert (t <= TIMEOUT_CYCLES) else
            stop_on_error($sformatf("timed out waiting for bench_cmd_ready, engine %0d", dest));
         @(posedge user_clk);
      end
      bench_cmd_valid <= 1'b0;
   endtask

   task automatic wait_results(input int n);
      int t;
      t = 0;
      while (res_engine.size() < n) begin
         @(posedge user_clk);
         t++;
         assert (t <= TIMEOUT_CYCLES) else
            stop_on_error($sformatf("timed out waiting for result number %0d", n));
      end
   endtask

   // expected strided pattern with the offset wrapping to zero past the region
   task automatic check_sequence(input bit e, input longint unsigned base,
                                 input longint unsigned size, input int num,
                                 input longint unsigned chunk,
                                 input longint unsigned stride, input bit is_write);
      longint unsigned off;
      longint unsigned nxt;
      int k;
      off = 0;
      k = 0;
      foreach (xfer_id[i]) begin
         if (xfer_id[i] == e) begin
            check_value("mem_cmd_addr", xfer_addr[i], base + off);
            check_value("mem_cmd_len", xfer_len[i], chunk);
            check_value("mem_cmd_op", xfer_op[i], is_write ? op_write : op_read);
            nxt = off + stride;
            off = (nxt + chunk > size) ? 0 : nxt;
            k++;
         end
      end
      check_value($sformatf("command count of engine %0d", e), k, num);
   endtask

   task automatic check_alternation(input int n0, input int n1);
      int c [2];
      int pairs;
      int j;
      c[0] = 0;
      c[1] = 0;
      pairs = 0;
      for (j = 0; j < xfer_id.size(); j++) begin
         // both engines still issuing, so grants must alternate
         if (j > 0 && c[0] > 0 && c[1] > 0 && c[0] < n0 && c[1] < n1) begin
            pairs++;
            assert (xfer_id[j] != xfer_id[j-1]) else
               stop_on_error($sformatf("engine %0d granted twice in a row at transfer %0d",
                                       xfer_id[j], j));
         end
         c[xfer_id[j]]++;
      end
      assert (pairs > 0) else stop_on_error("the two runs never competed for the memory port");
   endtask

   task automatic reset_test();
      int t;
      t = 0;
      repeat (10) @(posedge user_clk);
      check_bit("bench_cmd_ready", bench_cmd_ready, 1'b0);
      user_aresetn <= 1'b1;
      @(posedge user_clk);
      check_bit("mem_cmd_valid", mem_cmd_valid, 1'b0);
      check_bit("result_valid", result_valid, 1'b0);
      while (bench_cmd_ready !== 1'b1) begin
         t++;
         assert (t <= TIMEOUT_CYCLES) else
            stop_on_error("bench_cmd_ready never rose after reset");
         @(posedge user_clk);
      end
   endtask

   task automatic read_wrap_test();
      int n;
      n = res_engine.size();
      clear_log();
      ready_random <= 1'b0;
      send_cmd(1'b0, 48'h1000, 48'h100, 8, 32'h40, 32'h50, 1'b0);
      wait_results(n + 1);
      check_value("result_engine", res_engine[n], 0);
      check_sequence(1'b0, 'h1000, 'h100, 8, 'h40, 'h50, 1'b0);
   endtask

   task automatic write_backpressure_test();
      int n;
      n = res_engine.size();
      clear_log();
      ready_random <= 1'b1;
      send_cmd(1'b1, 48'h2000_0000, 48'h1000, 7, 32'h100, 32'h300, 1'b1);
      wait_results(n + 1);
      repeat (10) @(posedge user_clk);  // no second result may follow
      check_value("result count", res_engine.size(), n + 1);
      check_value("result_engine", res_engine[n], 1);
      check_value("transfer count", xfer_id.size(), 7);
      check_sequence(1'b1, 'h2000_0000, 'h1000, 7, 'h100, 'h300, 1'b1);
   endtask

   task automatic overlap_test();
      int n;
      n = res_engine.size();
      clear_log();
      ready_random <= 1'b0;
      send_cmd(1'b0, 48'h0, 48'h800, 6, 32'h80, 32'h180, 1'b0);
      send_cmd(1'b1, 48'h10000, 48'h400, 6, 32'h40, 32'h100, 1'b1);
      wait_results(n + 2);
      check_value("result_engine pair", res_engine[n] ^ res_engine[n+1], 1);
      check_sequence(1'b0, 'h0, 'h800, 6, 'h80, 'h180, 1'b0);
      check_sequence(1'b1, 'h10000, 'h400, 6, 'h40, 'h100, 1'b1);
      check_alternation(6, 6);
   endtask

   task automatic busy_engine_test();
      int n;
      int hs_before;
      n = res_engine.size();
      clear_log();
      ready_random <= 1'b1;
      send_cmd(1'b0, 48'h4000, 48'h200, 16, 32'h20, 32'h60, 1'b0);
      @(posedge user_clk);
      hs_before = hs_cnt;
      bench_cmd_valid <= 1'b1;  // second command for the running engine
      bench_cmd_dest  <= 1'b0;
      repeat (3) begin
         @(posedge user_clk);
         check_bit("bench_cmd_ready", bench_cmd_ready, 1'b0);
      end
      bench_cmd_valid <= 1'b0;
      @(posedge user_clk);
      check_value("handshake count", hs_cnt, hs_before);
      send_cmd(1'b1, 48'h8000, 48'h100, 3, 32'h10, 32'h10, 1'b1);
      check_value("result count", res_engine.size(), n);  // engine 0 still running
      wait_results(n + 2);
      check_value("result_engine pair", res_engine[n] ^ res_engine[n+1], 1);
      check_sequence(1'b0, 'h4000, 'h200, 16, 'h20, 'h60, 1'b0);
      check_sequence(1'b1, 'h8000, 'h100, 3, 'h10, 'h10, 1'b1);
   endtask

   task automatic cycle_count_test();
      foreach (res_cycles[i]) begin
         check_value($sformatf("result_cycles of result %0d", i), res_cycles[i], res_exp[i]);
         assert (res_lag[i] == 1 || res_lag[i] == 2) else
            stop_on_error($sformatf("result %0d came %0d cycles after the last completion",
                                    i, res_lag[i]));
      end
   endtask

   initial begin
      user_clk               = 1'b0;
      user_aresetn           = 1'b0;
      bench_cmd_valid        = 1'b0;
      bench_cmd_dest         = '0;
      bench_cmd_base         = '0;
      bench_cmd_mem_size     = '0;
      bench_cmd_num_accesses = '0;
      bench_cmd_chunk_len    = '0;
      bench_cmd_stride       = '0;
      bench_cmd_is_write     = 1'b0;
      mem_cmd_ready          = 1'b0;
      mem_done               = 1'b0;
      mem_done_id            = '0;
      ready_random           = 1'b0;
      reset_test();
      read_wrap_test();
      write_backpressure_test();
      overlap_test();
      busy_engine_test();
      cycle_count_test();
      repeat (5) @(posedge user_clk);
      if (u_dut.u_assert.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_on_error($sformatf("%0d protocol assertion failures", u_dut.u_assert.fail_cnt));
      end
   end

endmodule

//--- logic/access_engine.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module access_engine (
   input  logic                         user_clk,
   input  logic                         user_aresetn,
   input  logic                         start,
   input  logic [`BENCH_ADDR_W-1:0]     cfg_base,
   input  logic [`BENCH_ADDR_W-1:0]     cfg_mem_size,
   input  logic [`BENCH_LEN_W-1:0]      cfg_num_accesses,
   input  logic [`BENCH_LEN_W-1:0]      cfg_chunk_len,
   input  logic [`BENCH_LEN_W-1:0]      cfg_stride,
   input  logic                         cfg_is_write,
   input  logic                         grant,
   input  logic                         mem_done,
   output logic                         busy,
   output logic                         req,
   output bench_pkg::mem_op_e           req_op,
   output logic [`BENCH_ADDR_W-1:0]     req_addr,
   output logic [`BENCH_LEN_W-1:0]      req_len,
   output logic                         done,
   output logic [`BENCH_CYCLES_W-1:0]   exec_cycles
);

   import bench_pkg::*;

   engine_state_e                state;
   logic [`BENCH_ADDR_W-1:0]     base_q;
   logic [`BENCH_ADDR_W-1:0]     mem_size_q;
   logic [`BENCH_LEN_W-1:0]      num_q;
   logic [`BENCH_LEN_W-1:0]      chunk_q;
   logic [`BENCH_LEN_W-1:0]      stride_q;
   logic                         is_write_q;
   logic [`BENCH_ADDR_W-1:0]     offset;
   logic [`BENCH_LEN_W-1:0]      issued_cnt;
   logic [`BENCH_LEN_W-1:0]      completed_cnt;
   logic [`BENCH_CYCLES_W-1:0]   cycle_cnt;
   logic [`BENCH_ADDR_W:0]       stride_ext;
   logic [`BENCH_ADDR_W:0]       chunk_ext;
   logic [`BENCH_ADDR_W:0]       step_sum;
   logic [`BENCH_ADDR_W-1:0]     next_offset;
   logic                         launch;
   logic                         last_issue;
   logic                         last_done;

   assign launch     = start && (state == st_idle);
   assign last_issue = (issued_cnt == num_q - 1'b1);
   assign last_done  = (completed_cnt == num_q - 1'b1);

   // one spare bit so the wrap compare cannot overflow
   assign stride_ext = {{(`BENCH_ADDR_W - `BENCH_LEN_W + 1){1'b0}}, stride_q};
   assign chunk_ext  = {{(`BENCH_ADDR_W - `BENCH_LEN_W + 1){1'b0}}, chunk_q};
   assign step_sum   = {1'b0, offset} + stride_ext;

   always_comb begin
      if (step_sum + chunk_ext > {1'b0, mem_size_q}) begin
         next_offset = '0;  // chunk would run past the region
      end else begin
         next_offset = step_sum[`BENCH_ADDR_W-1:0];
      end
   end

   assign busy     = (state != st_idle);
   assign req      = (state == st_issue);
   assign req_op   = is_write_q ? op_write : op_read;
   assign req_addr = base_q + offset;
   assign req_len  = chunk_q;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         state <= st_idle;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            st_idle: begin
               if (launch) begin
                  if (cfg_num_accesses == '0) begin
                     done <= 1'b1;  // empty run finishes at once
                  end else begin
                     state <= st_issue;
                  end
               end
            end
            st_issue: begin
               if (grant && last_issue) begin
                  state <= st_drain;
               end
            end
            st_drain: begin
               if (mem_done && last_done) begin
                  state <= st_idle;
                  done  <= 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge user_clk) begin
      if (launch) begin
         base_q        <= cfg_base;
         mem_size_q    <= cfg_mem_size;
         num_q         <= cfg_num_accesses;
         chunk_q       <= cfg_chunk_len;
         stride_q      <= cfg_stride;
         is_write_q    <= cfg_is_write;
         offset        <= '0;
         issued_cnt    <= '0;
         completed_cnt <= '0;
         cycle_cnt     <= `BENCH_CYCLES_W'(1);  // start cycle counts as one
         if (cfg_num_accesses == '0) begin
            exec_cycles <= `BENCH_CYCLES_W'(1);
         end
      end else begin
         if (state != st_idle) begin
            cycle_cnt <= cycle_cnt + 1'b1;
         end
         if (grant) begin
            offset     <= next_offset;
            issued_cnt <= issued_cnt + 1'b1;
         end
         if (mem_done) begin
            completed_cnt <= completed_cnt + 1'b1;
         end
         if (state == st_drain && mem_done && last_done) begin
            exec_cycles <= cycle_cnt + 1'b1;  // include the final done cycle
         end
      end
   end

endmodule

//--- logic/bench_ctrl.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module bench_ctrl (
   input  logic                            user_clk,
   input  logic                            user_aresetn,
   input  logic                            bench_cmd_valid,
   input  logic [`BENCH_ID_W-1:0]          bench_cmd_dest,
   input  logic [`BENCH_ADDR_W-1:0]        bench_cmd_base,
   input  logic [`BENCH_ADDR_W-1:0]        bench_cmd_mem_size,
   input  logic [`BENCH_LEN_W-1:0]         bench_cmd_num_accesses,
   input  logic [`BENCH_LEN_W-1:0]         bench_cmd_chunk_len,
   input  logic [`BENCH_LEN_W-1:0]         bench_cmd_stride,
   input  logic                            bench_cmd_is_write,
   input  logic [`BENCH_NUM_ENGINES-1:0]   engine_busy,
   input  logic [`BENCH_NUM_ENGINES-1:0]   engine_done,
   input  logic [`BENCH_CYCLES_W-1:0]      engine_cycles [`BENCH_NUM_ENGINES],
   output logic                            bench_cmd_ready,
   output logic [`BENCH_NUM_ENGINES-1:0]   start,
   output logic [`BENCH_ADDR_W-1:0]        cfg_base,
   output logic [`BENCH_ADDR_W-1:0]        cfg_mem_size,
   output logic [`BENCH_LEN_W-1:0]         cfg_num_accesses,
   output logic [`BENCH_LEN_W-1:0]         cfg_chunk_len,
   output logic [`BENCH_LEN_W-1:0]         cfg_stride,
   output logic                            cfg_is_write,
   output logic                            result_valid,
   output logic [`BENCH_ID_W-1:0]          result_engine,
   output logic [`BENCH_CYCLES_W-1:0]      result_cycles
);

   logic   cmd_en;      // low until the first clock out of reset
   logic   pend_valid;  // engine 1 result held back one cycle
   logic   cmd_take;

   // a start in flight counts as busy, engine busy rises a cycle later
   assign bench_cmd_ready = cmd_en && !engine_busy[bench_cmd_dest] && !start[bench_cmd_dest];
   assign cmd_take        = bench_cmd_valid && bench_cmd_ready;

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         cmd_en     <= 1'b0;
         start      <= '0;
         pend_valid <= 1'b0;
      end else begin
         cmd_en <= 1'b1;
         start  <= '0;
         if (cmd_take) begin
            start[bench_cmd_dest] <= 1'b1;
         end
         pend_valid <= engine_done[0] && engine_done[1];  // both finished together
      end
   end

   always_ff @(posedge user_clk) begin
      if (cmd_take) begin
         cfg_base         <= bench_cmd_base;
         cfg_mem_size     <= bench_cmd_mem_size;
         cfg_num_accesses <= bench_cmd_num_accesses;
         cfg_chunk_len    <= bench_cmd_chunk_len;
         cfg_stride       <= bench_cmd_stride;
         cfg_is_write     <= bench_cmd_is_write;
      end
   end

   // engine 0 wins a tie, engine 1 follows from the pending slot
   assign result_valid  = pend_valid || (|engine_done);
   assign result_engine = (pend_valid || !engine_done[0]) ? `BENCH_ID_W'(1) : `BENCH_ID_W'(0);
   assign result_cycles = engine_cycles[result_engine];  // engines hold their count

endmodule

//--- logic/bench_defines.svh
`ifndef BENCH_DEFINES_SVH
`define BENCH_DEFINES_SVH

// address and memory size width
`define BENCH_ADDR_W 48

// access count, chunk length and stride
`define BENCH_LEN_W 32

// execution cycle result
`define BENCH_CYCLES_W 64

// engines behind the shared memory port
`define BENCH_NUM_ENGINES 2

// engine index on memory commands and completions
`define BENCH_ID_W 1

`endif

//--- logic/bench_pkg.sv
package bench_pkg;

   // engine run phases
   typedef enum logic [1:0] {
      st_idle  = 2'd0,  // waiting for start
      st_issue = 2'd1,  // commands left to send
      st_drain = 2'd2   // all sent, collecting completions
   } engine_state_e;

   // memory command opcode
   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

endpackage

//--- logic/bench_top.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module bench_top (
   input  logic                         user_clk,
   input  logic                         user_aresetn,
   input  logic                         bench_cmd_valid,
   output logic                         bench_cmd_ready,
   input  logic [`BENCH_ID_W-1:0]       bench_cmd_dest,
   input  logic [`BENCH_ADDR_W-1:0]     bench_cmd_base,
   input  logic [`BENCH_ADDR_W-1:0]     bench_cmd_mem_size,
   input  logic [`BENCH_LEN_W-1:0]      bench_cmd_num_accesses,
   input  logic [`BENCH_LEN_W-1:0]      bench_cmd_chunk_len,
   input  logic [`BENCH_LEN_W-1:0]      bench_cmd_stride,
   input  logic                         bench_cmd_is_write,
   output logic                         mem_cmd_valid,
   input  logic                         mem_cmd_ready,
   output logic [`BENCH_ID_W-1:0]       mem_cmd_id,
   output bench_pkg::mem_op_e           mem_cmd_op,
   output logic [`BENCH_ADDR_W-1:0]     mem_cmd_addr,
   output logic [`BENCH_LEN_W-1:0]      mem_cmd_len,
   input  logic                         mem_done,
   input  logic [`BENCH_ID_W-1:0]       mem_done_id,
   output logic                         result_valid,
   output logic [`BENCH_ID_W-1:0]       result_engine,
   output logic [`BENCH_CYCLES_W-1:0]   result_cycles
);

   import bench_pkg::*;

   logic [`BENCH_NUM_ENGINES-1:0]   engine_busy;
   logic [`BENCH_NUM_ENGINES-1:0]   engine_done;
   logic [`BENCH_CYCLES_W-1:0]      engine_cycles [`BENCH_NUM_ENGINES];
   logic [`BENCH_NUM_ENGINES-1:0]   start;
   logic [`BENCH_ADDR_W-1:0]        cfg_base;
   logic [`BENCH_ADDR_W-1:0]        cfg_mem_size;
   logic [`BENCH_LEN_W-1:0]         cfg_num_accesses;
   logic [`BENCH_LEN_W-1:0]         cfg_chunk_len;
   logic [`BENCH_LEN_W-1:0]         cfg_stride;
   logic                            cfg_is_write;
   logic [`BENCH_NUM_ENGINES-1:0]   req;
   mem_op_e                         req_op [`BENCH_NUM_ENGINES];
   logic [`BENCH_ADDR_W-1:0]        req_addr [`BENCH_NUM_ENGINES];
   logic [`BENCH_LEN_W-1:0]         req_len [`BENCH_NUM_ENGINES];
   logic [`BENCH_NUM_ENGINES-1:0]   grant;
   logic [`BENCH_NUM_ENGINES-1:0]   eng_mem_done;  // completions per engine

   bench_ctrl u_ctrl (
      .user_clk               (user_clk),
      .user_aresetn           (user_aresetn),
      .bench_cmd_valid        (bench_cmd_valid),
      .bench_cmd_dest         (bench_cmd_dest),
      .bench_cmd_base         (bench_cmd_base),
      .bench_cmd_mem_size     (bench_cmd_mem_size),
      .bench_cmd_num_accesses (bench_cmd_num_accesses),
      .bench_cmd_chunk_len    (bench_cmd_chunk_len),
      .bench_cmd_stride       (bench_cmd_stride),
      .bench_cmd_is_write     (bench_cmd_is_write),
      .engine_busy            (engine_busy),
      .engine_done            (engine_done),
      .engine_cycles          (engine_cycles),
      .bench_cmd_ready        (bench_cmd_ready),
      .start                  (start),
      .cfg_base               (cfg_base),
      .cfg_mem_size           (cfg_mem_size),
      .cfg_num_accesses       (cfg_num_accesses),
      .cfg_chunk_len          (cfg_chunk_len),
      .cfg_stride             (cfg_stride),
      .cfg_is_write           (cfg_is_write),
      .result_valid           (result_valid),
      .result_engine          (result_engine),
      .result_cycles          (result_cycles)
   );

   access_engine u_engine_0 (
      .user_clk         (user_clk),
      .user_aresetn     (user_aresetn),
      .start            (start[0]),
      .cfg_base         (cfg_base),
      .cfg_mem_size     (cfg_mem_size),
      .cfg_num_accesses (cfg_num_accesses),
      .cfg_chunk_len    (cfg_chunk_len),
      .cfg_stride       (cfg_stride),
      .cfg_is_write     (cfg_is_write),
      .grant            (grant[0]),
      .mem_done         (eng_mem_done[0]),
      .busy             (engine_busy[0]),
      .req              (req[0]),
      .req_op           (req_op[0]),
      .req_addr         (req_addr[0]),
      .req_len          (req_len[0]),
      .done             (engine_done[0]),
      .exec_cycles      (engine_cycles[0])
   );

   access_engine u_engine_1 (
      .user_clk         (user_clk),
      .user_aresetn     (user_aresetn),
      .start            (start[1]),
      .cfg_base         (cfg_base),
      .cfg_mem_size     (cfg_mem_size),
      .cfg_num_accesses (cfg_num_accesses),
      .cfg_chunk_len    (cfg_chunk_len),
      .cfg_stride       (cfg_stride),
      .cfg_is_write     (cfg_is_write),
      .grant            (grant[1]),
      .mem_done         (eng_mem_done[1]),
      .busy             (engine_busy[1]),
      .req              (req[1]),
      .req_op           (req_op[1]),
      .req_addr         (req_addr[1]),
      .req_len          (req_len[1]),
      .done             (engine_done[1]),
      .exec_cycles      (engine_cycles[1])
   );

   cmd_arbiter u_arbiter (
      .user_clk      (user_clk),
      .user_aresetn  (user_aresetn),
      .req           (req),
      .req_op        (req_op),
      .req_addr      (req_addr),
      .req_len       (req_len),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_done      (mem_done),
      .mem_done_id   (mem_done_id),
      .grant         (grant),
      .done          (eng_mem_done),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_id    (mem_cmd_id),
      .mem_cmd_op    (mem_cmd_op),
      .mem_cmd_addr  (mem_cmd_addr),
      .mem_cmd_len   (mem_cmd_len)
   );

endmodule

//--- logic/cmd_arbiter.sv
`timescale 1ns/1ps
`include "bench_defines.svh"

module cmd_arbiter (
   input  logic                            user_clk,
   input  logic                            user_aresetn,
   input  logic [`BENCH_NUM_ENGINES-1:0]   req,
   input  bench_pkg::mem_op_e              req_op [`BENCH_NUM_ENGINES],
   input  logic [`BENCH_ADDR_W-1:0]        req_addr [`BENCH_NUM_ENGINES],
   input  logic [`BENCH_LEN_W-1:0]         req_len [`BENCH_NUM_ENGINES],
   input  logic                            mem_cmd_ready,
   input  logic                            mem_done,
   input  logic [`BENCH_ID_W-1:0]          mem_done_id,
   output logic [`BENCH_NUM_ENGINES-1:0]   grant,
   output logic [`BENCH_NUM_ENGINES-1:0]   done,
   output logic                            mem_cmd_valid,
   output logic [`BENCH_ID_W-1:0]          mem_cmd_id,
   output bench_pkg::mem_op_e              mem_cmd_op,
   output logic [`BENCH_ADDR_W-1:0]        mem_cmd_addr,
   output logic [`BENCH_LEN_W-1:0]         mem_cmd_len
);

   logic [`BENCH_ID_W-1:0]   rr_ptr;    // engine with priority
   logic [`BENCH_ID_W-1:0]   sel_q;     // engine held during a stall
   logic                     locked_q;
   logic [`BENCH_ID_W-1:0]   sel;

   always_comb begin
      if (locked_q) begin
         sel = sel_q;
      end else if (req[rr_ptr]) begin
         sel = rr_ptr;
      end else begin
         sel = ~rr_ptr;  // only two engines, so the other one
      end
   end

   assign mem_cmd_valid = req[sel];
   assign mem_cmd_id    = sel;
   assign mem_cmd_op    = req_op[sel];
   assign mem_cmd_addr  = req_addr[sel];
   assign mem_cmd_len   = req_len[sel];

   always_comb begin
      grant = '0;
      if (mem_cmd_valid && mem_cmd_ready) begin
         grant[sel] = 1'b1;
      end
   end

   // completions go back by id
   always_comb begin
      done = '0;
      if (mem_done) begin
         done[mem_done_id] = 1'b1;
      end
   end

   always_ff @(posedge user_clk) begin
      if (!user_aresetn) begin
         rr_ptr   <= '0;
         sel_q    <= '0;
         locked_q <= 1'b0;
      end else begin
         if (mem_cmd_valid && mem_cmd_ready) begin
            rr_ptr   <= ~sel;  // other engine goes first next time
            locked_q <= 1'b0;
         end else if (mem_cmd_valid) begin
            sel_q    <= sel;   // stalled, keep fields stable
            locked_q <= 1'b1;
         end
      end
   end

endmodule

//--- src.f
+incdir+logic
logic/bench_pkg.sv
logic/access_engine.sv
logic/cmd_arbiter.sv
logic/bench_ctrl.sv
logic/bench_top.sv
dv/bench_assertions.sv
dv/bench_tb.sv
